// ==== rtl/pdp8_defs.svh ====
//**********************************************************
// PDP-8 accumulator widths and codes
//**********************************************************
`ifndef PDP8_DEFS_SVH
`define PDP8_DEFS_SVH

// machine word and EAE step counter
`define PDP8_WORD_W 12
`define PDP8_SC_W 5

// iterations of a multiply
`define PDP8_MUL_STEPS 12

// mode A shift count that saturates without iterating
`define PDP8_SHIFT_LIMIT 24

// major opcodes, instruction bits 0 to 2
`define PDP8_OP_AND 3'o0
`define PDP8_OP_TAD 3'o1
`define PDP8_OP_DCA 3'o3

// EAE mode A instructions, matched on the whole word
`define PDP8_EAE_MUL 12'o7405
`define PDP8_EAE_SHL 12'o7413
`define PDP8_EAE_ASR 12'o7415
`define PDP8_EAE_LSR 12'o7417

`endif

// ==== rtl/pdp8_ac_pkg.sv ====
//**********************************************************
// Accumulator datapath types
//**********************************************************
`include "pdp8_defs.svh"

package pdp8_ac_pkg;

    // bit 0 is the most significant, as on the machine
    typedef logic [0:`PDP8_WORD_W-1] word_t;

    // architectural state, 25 bits
    typedef struct packed {
        logic  link;
        word_t ac;
        word_t mq;  // multiplier-quotient
    } ac_state_t;

    // one command as offered by the processor
    typedef struct packed {
        word_t instr;
        word_t operand;  // memory data for memref and eae
    } ac_cmd_t;

    // EAE operations kept in mode A
    typedef enum logic [1:0] {
        EAE_MUL,
        EAE_SHL,
        EAE_ASR,
        EAE_LSR
    } eae_op_t;

endpackage

// ==== rtl/operate_microcode.sv ====
//**********************************************************
// Operate group 1 and group 3 micro-ops
//**********************************************************
`timescale 1ns/10ps

module operate_microcode (
    input  pdp8_ac_pkg::ac_cmd_t   cmd,
    input  pdp8_ac_pkg::ac_state_t state,
    output pdp8_ac_pkg::ac_state_t next
);

    pdp8_ac_pkg::word_t     instr;
    pdp8_ac_pkg::word_t     a1;       // ac after clear and complement
    logic                   l1;
    pdp8_ac_pkg::word_t     a2;       // ac after increment
    logic                   l2;
    pdp8_ac_pkg::ac_state_t g1_next;
    pdp8_ac_pkg::ac_state_t g3_next;
    logic [2:0]             g3_sel;

    assign instr  = cmd.instr;
    assign g3_sel = {instr[4], instr[5], instr[7]};  // cla, mqa, mql

    // group 1 first stages: clear, complement, then increment
    always_comb
    begin
        a1 = instr[4] ? '0 : state.ac;      // cla
        l1 = instr[5] ? 1'b0 : state.link;  // cll
        if (instr[6])
            a1 = ~a1;                       // cma
        if (instr[7])
            l1 = ~l1;                       // cml
        {l2, a2} = {l1, a1} + {12'd0, instr[11]};  // iac carries into link
    end

    // rotate field last
    always_comb
    begin
        g1_next.mq   = state.mq;
        g1_next.link = l2;
        g1_next.ac   = a2;
        case (instr[8:10])
            3'b001: g1_next.ac = {a2[6:11], a2[0:5]};                         // bsw
            3'b010: {g1_next.link, g1_next.ac} = {a2, l2};                    // ral
            3'b011: {g1_next.link, g1_next.ac} = {a2[1:11], l2, a2[0]};       // rtl
            3'b100: {g1_next.link, g1_next.ac} = {a2[11], l2, a2[0:10]};      // rar
            3'b101: {g1_next.link, g1_next.ac} = {a2[10], a2[11], l2, a2[0:9]};  // rtr
            default: ;  // unused codes keep the value
        endcase
    end

    // group 3 register transfers
    always_comb
    begin
        g3_next = state;
        case (g3_sel)
            3'b001:  // mql
            begin
                g3_next.mq = state.ac;
                g3_next.ac = '0;
            end
            3'b010: g3_next.ac = state.ac | state.mq;  // mqa
            3'b011:  // swp
            begin
                g3_next.mq = state.ac;
                g3_next.ac = state.mq;
            end
            3'b100: g3_next.ac = '0;  // cla
            3'b101:  // cam
            begin
                g3_next.mq = '0;
                g3_next.ac = '0;
            end
            3'b110: g3_next.ac = state.mq;  // acl
            3'b111:  // cla swp
            begin
                g3_next.mq = '0;
                g3_next.ac = state.mq;
            end
            default: ;  // nop
        endcase
    end

    always_comb
    begin
        if (instr[0:3] == 4'b1110)
            next = g1_next;
        else if ((instr[0:3] == 4'b1111) && instr[11] && (instr[8:10] == 3'b000))
            next = g3_next;
        else
            next = state;
    end

endmodule

// ==== rtl/memory_reference_alu.sv ====
//**********************************************************
// Memory reference AND, TAD, DCA
//**********************************************************
`timescale 1ns/10ps
`include "pdp8_defs.svh"

module memory_reference_alu (
    input  pdp8_ac_pkg::ac_cmd_t   cmd,
    input  pdp8_ac_pkg::ac_state_t state,
    output pdp8_ac_pkg::ac_state_t next
);

    logic [`PDP8_WORD_W:0] tad_sum;  // link and ac together

    // carry out of ac flips the link
    assign tad_sum = {state.link, state.ac} + {1'b0, cmd.operand};

    always_comb
    begin
        next = state;
        case (cmd.instr[0:2])
            `PDP8_OP_AND: next.ac = state.ac & cmd.operand;
            `PDP8_OP_TAD:
            begin
                next.link = tad_sum[`PDP8_WORD_W];
                next.ac   = tad_sum[`PDP8_WORD_W-1:0];
            end
            `PDP8_OP_DCA: next.ac = '0;  // ac already deposited
            default: ;
        endcase
    end

endmodule

// ==== rtl/eae_shift_multiply.sv ====
//**********************************************************
// EAE multiply and shift sequencer
//**********************************************************
`timescale 1ns/10ps
`include "pdp8_defs.svh"

module eae_shift_multiply (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    eae_start,
    input  pdp8_ac_pkg::eae_op_t    eae_op,
    input  logic [`PDP8_SC_W-1:0]   eae_count,
    input  pdp8_ac_pkg::ac_state_t  start_state,
    input  pdp8_ac_pkg::word_t      operand,
    output pdp8_ac_pkg::ac_state_t  result,
    output logic                    eae_finish
);

    pdp8_ac_pkg::ac_state_t work;          // working copy of link, ac, mq
    pdp8_ac_pkg::eae_op_t   op_q;
    pdp8_ac_pkg::word_t     multiplicand;
    logic [`PDP8_SC_W-1:0]  sc;            // step counter
    logic                   running;
    logic                   saturate;
    logic [`PDP8_WORD_W:0]  mul_sum;

    assign saturate = (eae_count >= `PDP8_SC_W'(`PDP8_SHIFT_LIMIT));
    assign mul_sum  = {1'b0, work.ac} + {1'b0, multiplicand};
    assign result   = work;

    // sequencing
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            running    <= 1'b0;
            eae_finish <= 1'b0;
            sc         <= '0;
        end
        else
        begin
            eae_finish <= 1'b0;
            if (eae_start)
            begin
                if (eae_op == pdp8_ac_pkg::EAE_MUL)
                begin
                    sc      <= `PDP8_SC_W'(`PDP8_MUL_STEPS);
                    running <= 1'b1;
                end
                else if (saturate)
                begin
                    sc         <= '0;
                    eae_finish <= 1'b1;  // nothing to iterate
                end
                else
                begin
                    sc      <= eae_count + `PDP8_SC_W'(1);
                    running <= 1'b1;
                end
            end
            else if (running)
            begin
                sc <= sc - `PDP8_SC_W'(1);
                if (sc == `PDP8_SC_W'(1))
                begin
                    running    <= 1'b0;
                    eae_finish <= 1'b1;
                end
            end
        end
    end

    // working registers
    always_ff @(posedge clk)
    begin
        if (eae_start)
        begin
            op_q         <= eae_op;
            multiplicand <= operand;
            work         <= start_state;
            case (eae_op)
                pdp8_ac_pkg::EAE_MUL: work.link <= 1'b0;
                pdp8_ac_pkg::EAE_ASR:
                    if (saturate)
                        work <= start_state.ac[0] ? '1 : '0;  // all sign bits
                    else
                        work.link <= start_state.ac[0];       // sign refills from link
                default:  // shl, lsr
                    if (saturate)
                        work <= '0;
                    else
                        work.link <= 1'b0;
            endcase
        end
        else if (running)
        begin
            case (op_q)
                pdp8_ac_pkg::EAE_MUL:
                    if (work.mq[11])
                        {work.ac, work.mq} <= {mul_sum, work.mq[0:10]};
                    else
                        {work.ac, work.mq} <= {1'b0, work.ac, work.mq[0:10]};
                pdp8_ac_pkg::EAE_SHL:
                    {work.link, work.ac, work.mq} <= {work.ac, work.mq, 1'b0};
                default:  // asr and lsr shift in the link
                    {work.ac, work.mq} <= {work.link, work.ac, work.mq[0:10]};
            endcase
        end
    end

endmodule

// ==== rtl/accumulator_registers.sv ====
//**********************************************************
// Link, ac and mq registers with dispatch
//**********************************************************
`timescale 1ns/10ps
`include "pdp8_defs.svh"

module accumulator_registers (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cmd_valid,
    input  pdp8_ac_pkg::ac_cmd_t    cmd,
    input  pdp8_ac_pkg::ac_state_t  operate_next,
    input  pdp8_ac_pkg::ac_state_t  memref_next,
    input  pdp8_ac_pkg::ac_state_t  eae_result,
    input  logic                    eae_finish,
    output pdp8_ac_pkg::ac_state_t  state,
    output pdp8_ac_pkg::ac_cmd_t    cur_cmd,
    output logic                    eae_start,
    output pdp8_ac_pkg::eae_op_t    eae_op,
    output logic [`PDP8_SC_W-1:0]   eae_count,
    output logic                    busy,
    output logic                    done
);

    pdp8_ac_pkg::word_t instr;
    logic               accept;
    logic               is_group1;
    logic               is_group3;
    logic               is_memref;
    logic               is_eae;

    assign instr     = cmd.instr;
    assign cur_cmd   = cmd;
    assign accept    = cmd_valid && !busy;  // commands during busy are dropped
    assign is_group1 = (instr[0:3] == 4'b1110);
    assign is_group3 = (instr[0:3] == 4'b1111) && instr[11] && (instr[8:10] == 3'b000);
    assign is_memref = (instr[0:2] == `PDP8_OP_AND) || (instr[0:2] == `PDP8_OP_TAD) ||
                       (instr[0:2] == `PDP8_OP_DCA);
    assign eae_start = accept && is_eae;
    assign eae_count = cmd.operand[7:11];

    // exact EAE codes only
    always_comb
    begin
        is_eae = 1'b1;
        eae_op = pdp8_ac_pkg::EAE_MUL;
        case (instr)
            `PDP8_EAE_MUL: eae_op = pdp8_ac_pkg::EAE_MUL;
            `PDP8_EAE_SHL: eae_op = pdp8_ac_pkg::EAE_SHL;
            `PDP8_EAE_ASR: eae_op = pdp8_ac_pkg::EAE_ASR;
            `PDP8_EAE_LSR: eae_op = pdp8_ac_pkg::EAE_LSR;
            default: is_eae = 1'b0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= '0;
            busy  <= 1'b0;
            done  <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (eae_finish)
            begin
                state <= eae_result;
                busy  <= 1'b0;
                done  <= 1'b1;
            end
            else if (accept)
            begin
                if (is_eae)
                    busy <= 1'b1;  // done waits for the sequencer
                else
                begin
                    done <= 1'b1;
                    if (is_group1 || is_group3)
                        state <= operate_next;
                    else if (is_memref)
                        state <= memref_next;
                end
            end
        end
    end

endmodule

// ==== rtl/pdp8_accumulator.sv ====
//**********************************************************
// Accumulator datapath top
//**********************************************************
`timescale 1ns/10ps
`include "pdp8_defs.svh"

module pdp8_accumulator (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cmd_valid,
    input  pdp8_ac_pkg::ac_cmd_t    cmd,
    output pdp8_ac_pkg::ac_state_t  state,
    output logic                    busy,
    output logic                    done
);

    pdp8_ac_pkg::ac_cmd_t   cur_cmd;
    pdp8_ac_pkg::ac_state_t operate_next;
    pdp8_ac_pkg::ac_state_t memref_next;
    pdp8_ac_pkg::ac_state_t eae_result;
    pdp8_ac_pkg::eae_op_t   eae_op;
    logic [`PDP8_SC_W-1:0]  eae_count;
    logic                   eae_start;
    logic                   eae_finish;

    accumulator_registers regs (
        .clk(clk), .reset(reset), .cmd_valid(cmd_valid), .cmd(cmd),
        .operate_next(operate_next), .memref_next(memref_next),
        .eae_result(eae_result), .eae_finish(eae_finish),
        .state(state), .cur_cmd(cur_cmd), .eae_start(eae_start),
        .eae_op(eae_op), .eae_count(eae_count), .busy(busy), .done(done)
    );

    operate_microcode opr (.cmd(cur_cmd), .state(state), .next(operate_next));

    memory_reference_alu mri (.cmd(cur_cmd), .state(state), .next(memref_next));

    eae_shift_multiply eae (
        .clk(clk), .reset(reset), .eae_start(eae_start), .eae_op(eae_op),
        .eae_count(eae_count), .start_state(state), .operand(cur_cmd.operand),
        .result(eae_result), .eae_finish(eae_finish)
    );

endmodule

// ==== bench/pdp8_accumulator_assert.sv ====
//**********************************************************
// Accumulator strobe and busy assertions
//**********************************************************
`timescale 1ns/10ps
`include "pdp8_defs.svh"

module pdp8_accumulator_assert (
    input logic                 clk,
    input logic                 reset,
    input logic                 cmd_valid,
    input pdp8_ac_pkg::ac_cmd_t cmd,
    input logic                 busy,
    input logic                 done
);

    logic accept;
    logic is_eae;
    logic pending;       // accepted command still owes a done
    int   failures = 0;  // failed assertions so far

    assign accept = cmd_valid && !busy;
    assign is_eae = (cmd.instr == `PDP8_EAE_MUL) || (cmd.instr == `PDP8_EAE_SHL) ||
                    (cmd.instr == `PDP8_EAE_ASR) || (cmd.instr == `PDP8_EAE_LSR);

    always_ff @(posedge clk)
    begin
        if (reset)
            pending <= 1'b0;
        else if (accept)
            pending <= 1'b1;
        else if (done)
            pending <= 1'b0;
    end

    done_single: assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else
        begin
            $error("done stayed high for more than one cycle");
            failures++;
        end
    reset_idle: assert property (@(posedge clk) reset |=> (!busy && !done))
        else
        begin
            $error("busy or done high after reset");
            failures++;
        end
    quick_done: assert property (@(posedge clk) disable iff (reset)
                                 (accept && !is_eae) |=> done)
        else
        begin
            $error("done did not follow a non-EAE command by one cycle");
            failures++;
        end
    done_owed: assert property (@(posedge clk) disable iff (reset) done |-> pending)
        else
        begin
            $error("done without an accepted command");
            failures++;
        end

endmodule

bind pdp8_accumulator pdp8_accumulator_assert checks (
    .clk(clk), .reset(reset), .cmd_valid(cmd_valid), .cmd(cmd), .busy(busy), .done(done)
);

// ==== bench/pdp8_accumulator_tb.sv ====
//**********************************************************
// Accumulator datapath testbench
//**********************************************************
`timescale 1ns/10ps
`include "pdp8_defs.svh"

module pdp8_accumulator_tb;

    localparam int N_G1 = 30;
    localparam int N_ROT = 20;
    localparam int N_MEM = 30;
    localparam int N_G3 = 24;
    localparam int N_MUL = 16;
    localparam int N_SHIFT = 30;
    localparam int N_CMDS = (N_G1 + N_ROT + N_MEM + N_G3 + N_MUL + N_SHIFT) * 6;
    localparam int CMD_CYCLES = `PDP8_SHIFT_LIMIT + 6;  // worst EAE shift plus idle
    localparam int WATCHDOG_NS = (N_CMDS * CMD_CYCLES + 100) * 10;

    logic                   clk;
    logic                   reset;
    logic                   cmd_valid;
    pdp8_ac_pkg::ac_cmd_t   cmd;
    pdp8_ac_pkg::ac_state_t state;
    logic                   busy;
    logic                   done;

    logic [31:0]            rng;
    pdp8_ac_pkg::ac_state_t model;  // expected architectural state
    pdp8_ac_pkg::ac_state_t expected_q[$];
    int                     value_errors = 0;
    int                     protocol_errors = 0;
    logic [4:0]             edge_count [0:5] = '{5'd0, 5'd23, 5'd24, 5'd31, 5'd24, 5'd31};

    pdp8_accumulator dut (
        .clk(clk), .reset(reset), .cmd_valid(cmd_valid), .cmd(cmd),
        .state(state), .busy(busy), .done(done)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic pdp8_ac_pkg::word_t random_word();
        rng = xorshift32(rng);
        return rng[11:0];
    endfunction

    function automatic pdp8_ac_pkg::ac_state_t expected_state(
        input pdp8_ac_pkg::ac_state_t s, input pdp8_ac_pkg::ac_cmd_t c);
        pdp8_ac_pkg::ac_state_t r;
        pdp8_ac_pkg::word_t     i;
        logic [11:0]            ac;
        logic [12:0]            v;  // link above ac
        logic [24:0]            w;
        logic [4:0]             n;
        r = s;
        i = c.instr;
        n = c.operand[7:11];
        if (i[0:3] == 4'b1110)
        begin
            v = {(s.link & ~i[5]) ^ i[7], (i[4] ? 12'd0 : s.ac) ^ {12{i[6]}}};
            v = v + i[11];
            case (i[8:10])
                3'b001: v = {v[12], v[5:0], v[11:6]};
                3'b010: v = (v << 1) | (v >> 12);
                3'b011: v = (v << 2) | (v >> 11);
                3'b100: v = (v >> 1) | (v << 12);
                3'b101: v = (v >> 2) | (v << 11);
                default: ;
            endcase
            {r.link, r.ac} = v;
        end
        else if ((i[0:3] == 4'b1111) && i[11] && (i[8:10] == 3'b000))
        begin
            ac = i[4] ? 12'd0 : s.ac;
            r.ac = (i[5] ? s.mq : 12'd0) | (i[7] ? 12'd0 : ac);
            r.mq = i[7] ? ac : s.mq;
        end
        else if (i == `PDP8_EAE_MUL)
        begin
            w = s.mq * c.operand + s.ac;
            r = {1'b0, w[23:0]};
        end
        else if ((i == `PDP8_EAE_SHL) || (i == `PDP8_EAE_LSR))
        begin
            w = {1'b0, s.ac, s.mq};
            if (n >= `PDP8_SHIFT_LIMIT)
                r = '0;
            else if (i == `PDP8_EAE_SHL)
                r = w << (n + 1);
            else
                r = w >> (n + 1);
        end
        else if (i == `PDP8_EAE_ASR)
        begin
            if (n >= `PDP8_SHIFT_LIMIT)
                r = s.ac[0] ? 25'h1ffffff : 25'h0;
            else
                r = {s.ac[0], $signed({s.ac, s.mq}) >>> (n + 1)};
        end
        else if (i[0:2] == `PDP8_OP_AND)
            r.ac = s.ac & c.operand;
        else if (i[0:2] == `PDP8_OP_TAD)
        begin
            v = s.ac + c.operand;
            r.ac = v[11:0];
            r.link = s.link ^ v[12];  // carry flips link
        end
        else if (i[0:2] == `PDP8_OP_DCA)
            r.ac = '0;
        return r;
    endfunction

    // one command, waits for its done; inject sends a stray command while busy
    task automatic run_command(input pdp8_ac_pkg::ac_cmd_t c, input logic inject);
        int   cycles;
        logic seen;
        logic injected;
        logic eae;
        eae = (c.instr == `PDP8_EAE_MUL) || (c.instr == `PDP8_EAE_SHL) ||
              (c.instr == `PDP8_EAE_ASR) || (c.instr == `PDP8_EAE_LSR);
        cycles = 0;
        seen = 1'b0;
        injected = 1'b0;
        @(negedge clk);
        cmd = c;
        cmd_valid = 1'b1;
        model = expected_state(model, c);
        expected_q.push_back(model);
        while (!seen && (cycles < `PDP8_SHIFT_LIMIT + 8))
        begin
            @(negedge clk);
            cycles++;
            cmd_valid = 1'b0;
            if ((cycles == 1) && (busy !== eae))
            begin
                $display("Error %0t ns: busy %b one cycle after command %o", $time, busy,
                         c.instr);
                protocol_errors++;
            end
            if (done)
            begin
                seen = 1'b1;
                if (busy !== 1'b0)
                begin
                    $display("Error %0t ns: busy still high with done", $time);
                    protocol_errors++;
                end
            end
            else if (inject && !injected && busy)
            begin
                cmd = '{instr: 12'o7240, operand: random_word()};  // cla cma
                cmd_valid = 1'b1;
                injected = 1'b1;
            end
        end
        if (!seen)
        begin
            $display("no done within %0d cycles of command %o", cycles, c.instr);
            protocol_errors++;
        end
        else if (!eae && (cycles != 1))
        begin
            $display("Error %0t ns: done %0d cycles after command %o", $time, cycles, c.instr);
            protocol_errors++;
        end
    endtask

    // random link, ac and mq loaded through real instructions
    task automatic randomize_state(input logic ones);
        pdp8_ac_pkg::ac_cmd_t c;
        c = '{instr: 12'o7300, operand: 12'o0};  // cla cll
        run_command(c, 1'b0);
        c = '{instr: 12'o1000, operand: random_word()};  // tad
        run_command(c, 1'b0);
        c.instr = 12'o7421;  // mql
        run_command(c, 1'b0);
        c = '{instr: 12'o1000, operand: ones ? 12'o7777 : random_word()};
        run_command(c, 1'b0);
        c.instr = random_word() & 12'o0001 ? 12'o7020 : 12'o7000;  // cml or nop
        run_command(c, 1'b0);
    endtask

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // compare every done against the expected queue
    initial
    begin
        pdp8_ac_pkg::ac_state_t exp;
        forever
        begin
            @(negedge clk);
            if (done && (expected_q.size() == 0))
            begin
                $display("done came at %0t ns without a command", $time);
                protocol_errors++;
            end
            else if (done)
            begin
                exp = expected_q.pop_front();
                if (state !== exp)
                begin
                    $display("Error %0t ns: state %b %o %o, expected %b %o %o", $time,
                             state.link, state.ac, state.mq, exp.link, exp.ac, exp.mq);
                    value_errors++;
                end
            end
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the run did not finish in time");
        $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        pdp8_ac_pkg::ac_cmd_t c;
        pdp8_ac_pkg::word_t   w;
        logic [2:0]           sel;
        reset = 1'b1;
        cmd_valid = 1'b0;
        cmd = '0;
        rng = 32'h56b3;
        model = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        if ((state !== '0) || (busy !== 1'b0) || (done !== 1'b0))
        begin
            $display("Error %0t ns: state, busy or done not clear after reset", $time);
            value_errors++;
        end
        for (int k = 0; k < N_G1; k++)
        begin
            randomize_state(k % 4 == 0);  // all ones ac tests the iac carry
            w = random_word();
            if (k % 4 == 0)
            begin
                w[4] = 1'b0;  // keep ac so iac carries out
                w[6] = 1'b0;
                w[11] = 1'b1;
            end
            c = '{instr: {4'b1110, w[4:11]}, operand: random_word()};
            run_command(c, 1'b0);
        end
        for (int k = 0; k < N_ROT; k++)
        begin
            randomize_state(1'b0);
            w = random_word();
            c = '{instr: {4'b1110, w[4:7], 3'(k % 5 + 1), w[11]}, operand: 12'o0};
            run_command(c, 1'b0);
        end
        for (int k = 0; k < N_MEM; k++)
        begin
            randomize_state(1'b0);
            w = random_word();
            c.instr = {(k % 3 == 2) ? `PDP8_OP_DCA : 3'(k % 3), w[3:11]};
            c.operand = random_word();
            run_command(c, 1'b0);
        end
        for (int k = 0; k < N_G3; k++)
        begin
            randomize_state(1'b0);
            sel = 3'(k);  // cla, mqa, mql
            c = '{instr: {4'b1111, sel[2], sel[1], 1'b0, sel[0], 4'b0001}, operand: 12'o0};
            run_command(c, 1'b0);
        end
        for (int k = 0; k < N_MUL; k++)
        begin
            randomize_state(1'b0);
            c = '{instr: `PDP8_EAE_MUL, operand: random_word()};
            run_command(c, k[0]);
        end
        for (int k = 0; k < N_SHIFT; k++)
        begin
            randomize_state(k == 4);  // negative ac before a saturating asr
            c.instr = (k % 3 == 0) ? `PDP8_EAE_SHL :
                      (k % 3 == 1) ? `PDP8_EAE_ASR : `PDP8_EAE_LSR;
            c.operand = random_word();
            if (k < 6)
                c.operand[7:11] = edge_count[k];
            run_command(c, k[0]);
        end
        repeat (2) @(negedge clk);
        $display("errors: value %0d, protocol %0d, assertion %0d", value_errors,
                 protocol_errors, dut.checks.failures);
        if ((value_errors == 0) && (protocol_errors == 0) && (dut.checks.failures == 0))
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+rtl
rtl/pdp8_ac_pkg.sv
rtl/operate_microcode.sv
rtl/memory_reference_alu.sv
rtl/eae_shift_multiply.sv
rtl/accumulator_registers.sv
rtl/pdp8_accumulator.sv
bench/pdp8_accumulator_assert.sv
bench/pdp8_accumulator_tb.sv
